// File: mem_pkg.sv
// Scratchpad memory geometry
package mem_pkg;

    // Word count of the scratchpad
    localparam int mem_depth = 16;

    // Bits per stored word
    localparam int mem_data_width = 32;

    // Binary word index width
    localparam int mem_addr_width = $clog2(mem_depth);

    // One RAM data word, also used for the per-bit write mask
    typedef logic [mem_data_width-1:0] mem_data_t;

    // Binary word index
    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // One-hot word select, one bit per word
    typedef logic [mem_depth-1:0] mem_sel_t;

endpackage

// File: wb_pkg.sv
// Wishbone bus definitions
package wb_pkg;

    // Byte address width on the bus
    localparam int wb_adr_width = 32;

    // Byte lanes per data word
    localparam int wb_sel_width = 4;

    typedef logic [wb_adr_width-1:0] wb_adr_t;

    typedef logic [wb_sel_width-1:0] wb_sel_t;

    // Slave controller states
    typedef enum logic {
        wb_idle,
        wb_ack
    } wb_state_t;

endpackage

// File: ram_port_if.sv
// Controller to RAM port
`timescale 1ns/1ps

interface ram_port_if;
    import mem_pkg::*;

    // Binary word index, decoded outside the RAM
    mem_addr_t addr;
    logic      en;
    logic      wr;
    mem_data_t bit_we;
    mem_data_t din;
    // Combinational read data
    mem_data_t dout;

    modport controller (
        output addr,
        output en,
        output wr,
        output bit_we,
        output din,
        input  dout
    );

    modport ram (
        input  en,
        input  wr,
        input  bit_we,
        input  din,
        output dout
    );

endinterface

// File: onehot_decoder.sv
// Binary to one-hot decoder
`timescale 1ns/1ps

module onehot_decoder (
    input  mem_pkg::mem_addr_t addr,
    output mem_pkg::mem_sel_t  sel
);
    import mem_pkg::*;

    // One output bit per word index
    always_comb begin
        sel = '0;
        for (int i = 0; i < mem_depth; i++) begin
            if (addr == mem_addr_width'(i)) begin
                sel[i] = 1'b1;
            end
        end
    end

    // Every known address must land on exactly one word
    always_comb begin
        if (!$isunknown(addr)) begin
            assert ($onehot(sel))
                else $error("decoder output %h is not one-hot for address %0d", sel, addr);
        end
    end

endmodule

// File: dffram_1a1w1r.sv
// Flip-flop RAM, single port
`timescale 1ns/1ps

module dffram_1a1w1r #(
    parameter int data_width = mem_pkg::mem_data_width,
    parameter int depth      = mem_pkg::mem_depth
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [depth-1:0] word_sel,
    ram_port_if.ram          port
);

    // Masked word outputs, packed side by side
    wire  [depth*data_width-1:0] word_rd;
    logic [data_width-1:0]       rd_or;
    logic                        wr_cycle;

    assign wr_cycle = port.en & port.wr;

    for (genvar i = 0; i < depth; i++) begin : g_word
        logic [data_width-1:0] q;
        logic [data_width-1:0] bit_en;

        // Bits written this cycle in this word
        assign bit_en = port.bit_we & {data_width{wr_cycle & word_sel[i]}};

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                q <= '0;
            end else begin
                q <= (q & ~bit_en) | (port.din & bit_en);
            end
        end

        // Unselected words contribute zero to the read OR
        assign word_rd[i*data_width +: data_width] = q & {data_width{word_sel[i]}};
    end

    // OR of all masked words
    always_comb begin
        rd_or = '0;
        for (int i = 0; i < depth; i++) begin
            rd_or = rd_or | word_rd[i*data_width +: data_width];
        end
    end

    assign port.dout = rd_or;

    // Decoder and controller must agree on a single target word
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        port.en |-> $onehot(word_sel)
    ) else $error("word_sel %h not one-hot during an access", word_sel);

endmodule

// File: wb_ram_slave.sv
// Wishbone classic slave for the RAM
`timescale 1ns/1ps

module wb_ram_slave (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  wb_pkg::wb_adr_t    adr,
    input  wb_pkg::wb_sel_t    sel,
    input  mem_pkg::mem_data_t dat_w,
    output mem_pkg::mem_data_t dat_r,
    output logic               ack,
    ram_port_if.controller     port
);
    import mem_pkg::*;
    import wb_pkg::*;

    wb_state_t state;
    logic      req;
    mem_data_t mask;

    assign req = cyc & stb;

    // Byte selects widened to one mask bit per data bit
    always_comb begin
        for (int i = 0; i < wb_sel_width; i++) begin
            mask[i*(mem_data_width/wb_sel_width) +: (mem_data_width/wb_sel_width)] =
                {(mem_data_width/wb_sel_width){sel[i]}};
        end
    end

    // Word index from adr[5:2], upper bits alias
    assign port.addr   = adr[mem_addr_width+1:2];
    assign port.en     = req && (state == wb_idle);
    assign port.wr     = we;
    assign port.bit_we = mask;
    assign port.din    = dat_w;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= wb_idle;
            ack   <= 1'b0;
            dat_r <= '0;
        end else begin
            case (state)
                wb_idle: begin
                    if (req) begin
                        // Access happens on this edge
                        state <= wb_ack;
                        ack   <= 1'b1;
                        dat_r <= port.dout;
                    end
                end
                wb_ack: begin
                    state <= wb_idle;
                    ack   <= 1'b0;
                end
                default: begin
                    state <= wb_idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // Master holds its request until it sees ack
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |-> (cyc && stb)
    ) else $error("ack high outside an active bus cycle");

    // One ack per request
    a_ack_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |=> !ack
    ) else $error("ack held high for two cycles");

endmodule

// File: wb_dffram_top.sv
// Wishbone scratchpad top level
`timescale 1ns/1ps

module wb_dffram_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  wb_pkg::wb_adr_t    adr,
    input  wb_pkg::wb_sel_t    sel,
    input  mem_pkg::mem_data_t dat_w,
    output mem_pkg::mem_data_t dat_r,
    output logic               ack
);
    import mem_pkg::*;

    mem_sel_t word_sel;

    ram_port_if ram_if ();

    wb_ram_slave i_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .sel   (sel),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .port  (ram_if.controller)
    );

    // Word index to one-hot select
    onehot_decoder i_decoder (
        .addr (ram_if.addr),
        .sel  (word_sel)
    );

    dffram_1a1w1r #(
        .data_width (mem_data_width),
        .depth      (mem_depth)
    ) i_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .word_sel (word_sel),
        .port     (ram_if.ram)
    );

endmodule

// File: tb_wb_dffram.sv
// Scratchpad memory testbench
`timescale 1ns/1ps

module tb_wb_dffram;
    import mem_pkg::*;
    import wb_pkg::*;

    localparam int ack_timeout  = 20;
    localparam int random_count = 200;
    localparam int run_limit_ns = 100_000;

    logic      clk;
    logic      rst_n;
    logic      cyc;
    logic      stb;
    logic      we;
    wb_adr_t   adr;
    wb_sel_t   sel;
    mem_data_t dat_w;
    mem_data_t dat_r;
    logic      ack;

    integer    seed;
    mem_data_t model [mem_depth];
    mem_data_t exp_q [$];
    mem_data_t act_q [$];
    int        reads_issued;
    int        reads_checked;

    wb_dffram_top i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .sel   (sel),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #4 clk = ~clk;

    // Reference merge of write data into a stored word, lane by lane
    function automatic mem_data_t merge_bytes(mem_data_t old_word, mem_data_t new_word,
                                              wb_sel_t lanes);
        mem_data_t result;
        result = old_word;
        for (int b = 0; b < wb_sel_width; b++) begin
            if (lanes[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Bits 5 to 2 pick the word, higher bits alias
    function automatic int word_index(wb_adr_t a);
        return int'(a[5:2]);
    endfunction

    // One classic cycle, started on a rising edge and ended once ack is seen
    task automatic bus_cycle(input logic write, input wb_adr_t a, input wb_sel_t s,
                             input mem_data_t d, output mem_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        sel   <= s;
        dat_w <= d;
        @(negedge clk);
        while (!ack && waited < ack_timeout) begin
            waited++;
            @(negedge clk);
        end
        assert (ack) else begin
            $display("Bus timeout at %0t: ack never came for address %h", $time, a);
            $display("Test failed");
            $fatal(1);
        end
        // ack is expected on the edge right after stb is sampled
        assert (waited == 1) else begin
            $display("ERR %0t ack latency expected 1 actual %0d", $time, waited);
            $display("Test failed");
            $fatal(1);
        end
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        assert (!ack) else begin
            $display("ERR %0t ack expected 0 actual %b", $time, ack);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic write_word(input wb_adr_t a, input wb_sel_t s, input mem_data_t d);
        mem_data_t unused;
        bus_cycle(1'b1, a, s, d, unused);
        model[word_index(a)] = merge_bytes(model[word_index(a)], d, s);
    endtask

    task automatic read_word(input wb_adr_t a);
        mem_data_t rdata;
        bus_cycle(1'b0, a, 4'hf, '0, rdata);
        exp_q.push_back(model[word_index(a)]);
        act_q.push_back(rdata);
        reads_issued++;
    endtask

    // Compare process
    always @(posedge clk) begin
        mem_data_t expected;
        mem_data_t actual;
        while (act_q.size() > 0) begin
            expected = exp_q.pop_front();
            actual   = act_q.pop_front();
            assert (actual === expected) else begin
                $display("ERR %0t dat_r expected %h actual %h", $time, expected, actual);
                $display("Test failed");
                $fatal(1);
            end
            reads_checked++;
        end
    end

    initial begin
        #(run_limit_ns);
        $display("Simulation ran past its time limit without finishing");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd_adr;
        logic [31:0] rnd_dat;
        clk           = 1'b0;
        rst_n         <= 1'b0;
        cyc           <= 1'b0;
        stb           <= 1'b0;
        we            <= 1'b0;
        adr           <= '0;
        sel           <= '0;
        dat_w         <= '0;
        seed          = 32'hff11_1525;
        reads_issued  = 0;
        reads_checked = 0;
        for (int i = 0; i < mem_depth; i++) begin
            model[i] = '0;
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);
        assert (!ack) else begin
            $display("ERR %0t ack expected 0 actual %b", $time, ack);
            $display("Test failed");
            $fatal(1);
        end
        assert (dat_r === '0) else begin
            $display("ERR %0t dat_r expected %h actual %h", $time, 32'h0, dat_r);
            $display("Test failed");
            $fatal(1);
        end

        // All words clear after reset
        for (int i = 0; i < mem_depth; i++) begin
            read_word(i * 4);
        end

        // Full-word writes, read back in a shuffled order
        for (int i = 0; i < mem_depth; i++) begin
            rnd = $random(seed);
            write_word(i * 4, 4'hf, rnd);
        end
        for (int i = 0; i < mem_depth; i++) begin
            read_word(((i * 5 + 3) % mem_depth) * 4);
        end

        // Partial lane writes
        for (int i = 0; i < mem_depth; i++) begin
            rnd = $random(seed);
            write_word(i * 4, i[3:0], rnd);
        end
        write_word(32'h14, 4'b0101, 32'hdead_beef);
        write_word(32'h14, 4'b1010, 32'h1234_5678);
        for (int i = 0; i < mem_depth; i++) begin
            read_word(i * 4);
        end

        // Upper address bits alias onto the same words
        write_word(32'habc0_0024, 4'hf, 32'hcafe_f00d);
        read_word(32'h0000_0024);
        write_word(32'h0000_0030, 4'hf, 32'h0bad_c0de);
        read_word(32'hffff_fff0);

        for (int n = 0; n < random_count; n++) begin
            rnd     = $random(seed);
            rnd_adr = $random(seed);
            rnd_dat = $random(seed);
            if (rnd[0]) begin
                write_word(rnd_adr, rnd[4:1], rnd_dat);
            end else begin
                read_word(rnd_adr);
            end
        end

        repeat (2) @(posedge clk);
        if (exp_q.size() == 0 && reads_checked == reads_issued) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Compare process checked %0d of %0d reads", reads_checked, reads_issued);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// File: src.f
mem_pkg.sv
wb_pkg.sv
ram_port_if.sv
onehot_decoder.sv
dffram_1a1w1r.sv
wb_ram_slave.sv
wb_dffram_top.sv
tb_wb_dffram.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_wb_dffram -f src.f -o tb_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulation exited with an error status"
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL: no pass message in log"; exit 1; }
echo "PASS"
